// File: hw/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Data and pc width.
`define XLEN 32

// Sequential pc increment.
`define PC_STEP 4

`endif

// File: hw/rv_pkg.sv
package rv_pkg;

  typedef enum logic [4:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b,
    alu_eq,
    alu_ne,
    alu_lt,
    alu_ge,
    alu_ltu,
    alu_geu
  } alu_op_t;

  typedef enum logic [1:0] {
    op1_reg,
    op1_fwd,
    op1_pc
  } op1_sel_t;

  typedef enum logic [1:0] {
    op2_reg,
    op2_fwd,
    op2_imm,
    op2_csr
  } op2_sel_t;

  typedef enum logic [1:0] {
    npc_seq,
    npc_jal,
    npc_jalr,
    npc_branch
  } npc_sel_t;

  // Writeback source. pcimm covers auipc.
  typedef enum logic [1:0] {
    wdata_alu,
    wdata_link,
    wdata_pcimm,
    wdata_csr
  } wdata_sel_t;

endpackage

// File: hw/rv_alu.sv
`include "rv_defines.svh"

module rv_alu
  import rv_pkg::*;
(
  input  alu_op_t           opcode,
  input  logic [`XLEN-1:0]  operand1,
  input  logic [`XLEN-1:0]  operand2,
  output logic [`XLEN-1:0]  result
);

  logic [4:0] shamt;
  logic       equal;
  logic       signed_lt;
  logic       unsigned_lt;

  assign shamt       = operand2[4:0];
  assign equal       = operand1 == operand2;
  assign signed_lt   = $signed(operand1) < $signed(operand2);
  assign unsigned_lt = operand1 < operand2;

  always_comb begin
    result = '0;
    case (opcode)
      alu_add:    result = operand1 + operand2;
      alu_sub:    result = operand1 - operand2;
      alu_sll:    result = operand1 << shamt;
      alu_slt:    result[0] = signed_lt;
      alu_sltu:   result[0] = unsigned_lt;
      alu_xor:    result = operand1 ^ operand2;
      alu_srl:    result = operand1 >> shamt;
      alu_sra:    result = $unsigned($signed(operand1) >>> shamt);
      alu_or:     result = operand1 | operand2;
      alu_and:    result = operand1 & operand2;
      alu_pass_b: result = operand2;
      // Branch compares leave a single flag in bit 0.
      alu_eq:     result[0] = equal;
      alu_ne:     result[0] = !equal;
      alu_lt:     result[0] = signed_lt;
      alu_ge:     result[0] = !signed_lt;
      alu_ltu:    result[0] = unsigned_lt;
      alu_geu:    result[0] = !unsigned_lt;
      default:    result = operand1 + operand2;
    endcase
  end

endmodule

// File: hw/rv_decoder.sv
`include "rv_defines.svh"

module rv_decoder
  import rv_pkg::*;
(
  input  logic               clock,
  input  logic               reset,
  input  logic               block,
  input  logic               clear_pipeline,
  input  logic               decode_valid,
  input  logic [31:0]        instr,
  output alu_op_t            alu_opcode,
  output op1_sel_t           op1_sel,
  output op2_sel_t           op2_sel,
  output logic               src2_sel,
  output npc_sel_t           npc_sel,
  output wdata_sel_t         wdata_sel,
  output logic [`XLEN-1:0]   imm,
  output logic               csr_write
);

  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_system = 7'b1110011;

  logic [6:0]        opcode;
  logic [4:0]        rd;
  logic [4:0]        rs1;
  logic [4:0]        rs2;
  logic [2:0]        funct3;
  logic [`XLEN-1:0]  imm_i;
  logic [`XLEN-1:0]  imm_s;
  logic [`XLEN-1:0]  imm_b;
  logic [`XLEN-1:0]  imm_u;
  logic [`XLEN-1:0]  imm_j;
  logic              uses_rs1;
  logic              uses_rs2;
  logic              writes_rd;
  logic [4:0]        last_rd;
  logic              last_wen;

  assign opcode = instr[6:0];
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b011:  return alu_sltu;
      3'b100:  return alu_xor;
      3'b101:  return alt ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  always_comb begin
    alu_opcode = alu_add;
    op1_sel    = op1_reg;
    op2_sel    = op2_imm;
    npc_sel    = npc_seq;
    wdata_sel  = wdata_alu;
    imm        = imm_i;
    csr_write  = 1'b0;
    uses_rs1   = 1'b0;
    uses_rs2   = 1'b0;
    writes_rd  = 1'b0;
    case (opcode)
      opc_lui: begin
        imm        = imm_u;
        alu_opcode = alu_pass_b;
        writes_rd  = 1'b1;
      end
      opc_auipc: begin
        imm       = imm_u;
        op1_sel   = op1_pc;
        wdata_sel = wdata_pcimm;
        writes_rd = 1'b1;
      end
      opc_jal: begin
        imm       = imm_j;
        op1_sel   = op1_pc;
        npc_sel   = npc_jal;
        wdata_sel = wdata_link;
        writes_rd = 1'b1;
      end
      opc_jalr: begin
        uses_rs1  = 1'b1;
        npc_sel   = npc_jalr;
        wdata_sel = wdata_link;
        writes_rd = 1'b1;
      end
      opc_branch: begin
        imm      = imm_b;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        op2_sel  = op2_reg;
        npc_sel  = npc_branch;
        case (funct3)
          3'b001:  alu_opcode = alu_ne;
          3'b100:  alu_opcode = alu_lt;
          3'b101:  alu_opcode = alu_ge;
          3'b110:  alu_opcode = alu_ltu;
          3'b111:  alu_opcode = alu_geu;
          default: alu_opcode = alu_eq;
        endcase
      end
      // Address add only; rs2 goes to store data.
      opc_store: begin
        imm      = imm_s;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      opc_op_imm: begin
        uses_rs1   = 1'b1;
        writes_rd  = 1'b1;
        alu_opcode = arith_op(funct3, instr[30] && funct3 == 3'b101);
      end
      opc_op: begin
        uses_rs1   = 1'b1;
        uses_rs2   = 1'b1;
        writes_rd  = 1'b1;
        op2_sel    = op2_reg;
        alu_opcode = arith_op(funct3, instr[30]);
      end
      opc_system: begin
        if (funct3 == 3'b001) begin
          // csrrw writes rs1 through unchanged.
          imm        = '0;
          uses_rs1   = 1'b1;
          alu_opcode = alu_or;
          wdata_sel  = wdata_csr;
          csr_write  = 1'b1;
          writes_rd  = 1'b1;
        end else if (funct3 == 3'b010) begin
          uses_rs1   = 1'b1;
          op2_sel    = op2_csr;
          alu_opcode = alu_or;
          wdata_sel  = wdata_csr;
          csr_write  = 1'b1;
          writes_rd  = 1'b1;
        end
      end
      default: ;
    endcase

    // Back-to-back dependency on the last destination.
    src2_sel = uses_rs2 && last_wen && rs2 == last_rd;
    if (uses_rs1 && last_wen && rs1 == last_rd) begin
      op1_sel = op1_fwd;
    end
    if (src2_sel && op2_sel == op2_reg) begin
      op2_sel = op2_fwd;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      last_wen <= 1'b0;
      last_rd  <= '0;
    end else if (!block) begin
      if (decode_valid && !clear_pipeline) begin
        // x0 is never recorded as a destination.
        last_wen <= writes_rd && rd != 5'd0;
        last_rd  <= rd;
      end else begin
        last_wen <= 1'b0;
        last_rd  <= '0;
      end
    end
  end

  // x0 never takes the forwarded value.
  assert property (@(posedge clock) disable iff (reset)
    (op1_sel != op1_fwd || rs1 != 5'd0) && (!src2_sel || rs2 != 5'd0))
    else $error("forwarding selected for x0");

endmodule

// File: hw/rv_execute.sv
`include "rv_defines.svh"

module rv_execute
  import rv_pkg::*;
(
  input  logic               clock,
  input  logic               reset,
  input  logic               block,
  input  logic               clear_pipeline,
  input  logic               decode_valid,
  input  logic [`XLEN-1:0]   idu_pc,
  input  logic [`XLEN-1:0]   src1,
  input  logic [`XLEN-1:0]   src2,
  input  logic [`XLEN-1:0]   csr_src,
  input  logic [`XLEN-1:0]   imm,
  input  alu_op_t            alu_opcode,
  input  op1_sel_t           op1_sel,
  input  op2_sel_t           op2_sel,
  input  logic               src2_sel,
  input  npc_sel_t           npc_sel,
  input  wdata_sel_t         wdata_sel,
  input  logic               csr_write,
  output logic [`XLEN-1:0]   exu_pc,
  output logic               execute_valid,
  output logic [`XLEN-1:0]   alu_result,
  output logic [`XLEN-1:0]   exu_npc,
  output logic [`XLEN-1:0]   exu_r_wdata,
  output logic [`XLEN-1:0]   csr_wdata,
  output logic [`XLEN-1:0]   wsrc,
  output logic               wrong_prediction
);

  alu_op_t           opcode;
  logic [`XLEN-1:0]  operand1;
  logic [`XLEN-1:0]  operand2;
  logic [`XLEN-1:0]  op1_next;
  logic [`XLEN-1:0]  op2_next;
  logic [`XLEN-1:0]  src2_next;
  logic [`XLEN-1:0]  snpc;
  logic [`XLEN-1:0]  dnpc;
  logic [`XLEN-1:0]  csr_old;
  logic [`XLEN-1:0]  csr_hold;
  npc_sel_t          npc_sel_q;
  wdata_sel_t        wdata_sel_q;
  logic              csr_write_q;

  rv_alu alu0 (
    .opcode   (opcode),
    .operand1 (operand1),
    .operand2 (operand2),
    .result   (alu_result)
  );

  // Operand selection, forwarding from our own writeback.
  assign src2_next = src2_sel ? exu_r_wdata : src2;

  always_comb begin
    case (op1_sel)
      op1_fwd: op1_next = exu_r_wdata;
      op1_pc:  op1_next = idu_pc;
      default: op1_next = src1;
    endcase
    case (op2_sel)
      op2_fwd: op2_next = exu_r_wdata;
      op2_imm: op2_next = imm;
      op2_csr: op2_next = csr_src;
      default: op2_next = src2;
    endcase
  end

  always_comb begin
    case (npc_sel_q)
      npc_jal:    exu_npc = dnpc;
      npc_jalr:   exu_npc = {alu_result[`XLEN-1:1], 1'b0};
      npc_branch: exu_npc = alu_result[0] ? dnpc : snpc;
      default:    exu_npc = snpc;
    endcase
    case (wdata_sel_q)
      wdata_link:  exu_r_wdata = snpc;
      wdata_pcimm: exu_r_wdata = dnpc;
      wdata_csr:   exu_r_wdata = csr_old;
      default:     exu_r_wdata = alu_result;
    endcase
  end

  assign csr_wdata = csr_write_q ? alu_result : csr_hold;

  always_ff @(posedge clock) begin
    if (reset) begin
      execute_valid    <= 1'b0;
      wrong_prediction <= 1'b0;
      csr_write_q      <= 1'b0;
      opcode           <= alu_add;
      npc_sel_q        <= npc_seq;
      wdata_sel_q      <= wdata_alu;
    end else if (!block) begin
      execute_valid    <= decode_valid && !clear_pipeline;
      // Predict not taken.
      wrong_prediction <= !clear_pipeline && execute_valid && exu_npc != snpc;
      csr_write_q      <= csr_write && decode_valid && !clear_pipeline;
      opcode           <= alu_opcode;
      npc_sel_q        <= npc_sel;
      wdata_sel_q      <= wdata_sel;
    end
  end

  always_ff @(posedge clock) begin
    if (!block) begin
      operand1 <= op1_next;
      operand2 <= op2_next;
      wsrc     <= src2_next;
      exu_pc   <= idu_pc;
      snpc     <= idu_pc + `PC_STEP;
      dnpc     <= idu_pc + imm;
      csr_old  <= csr_src;
      if (csr_write_q) begin
        csr_hold <= alu_result;
      end
    end
  end

  assert property (@(posedge clock) disable iff (reset)
    !block && !execute_valid |=> !wrong_prediction)
    else $error("misprediction flagged for an invalid instruction");

  assert property (@(posedge clock) disable iff (reset)
    block |=> $stable({exu_pc, execute_valid, alu_result, exu_npc,
                       exu_r_wdata, csr_wdata, wsrc, wrong_prediction}))
    else $error("execute outputs changed during a stall");

endmodule

// File: hw/rv_execute_top.sv
`include "rv_defines.svh"

module rv_execute_top
  import rv_pkg::*;
(
  input  logic               clock,
  input  logic               reset,
  input  logic               block,
  input  logic               clear_pipeline,
  input  logic               decode_valid,
  input  logic [31:0]        instr,
  input  logic [`XLEN-1:0]   idu_pc,
  input  logic [`XLEN-1:0]   src1,
  input  logic [`XLEN-1:0]   src2,
  input  logic [`XLEN-1:0]   csr_src,
  output logic [`XLEN-1:0]   exu_pc,
  output logic               execute_valid,
  output logic [`XLEN-1:0]   alu_result,
  output logic [`XLEN-1:0]   exu_npc,
  output logic [`XLEN-1:0]   exu_r_wdata,
  output logic [`XLEN-1:0]   csr_wdata,
  output logic [`XLEN-1:0]   wsrc,
  output logic               wrong_prediction
);

  alu_op_t           alu_opcode;
  op1_sel_t          op1_sel;
  op2_sel_t          op2_sel;
  logic              src2_sel;
  npc_sel_t          npc_sel;
  wdata_sel_t        wdata_sel;
  logic [`XLEN-1:0]  imm;
  logic              csr_write;

  rv_decoder decoder0 (
    .clock          (clock),
    .reset          (reset),
    .block          (block),
    .clear_pipeline (clear_pipeline),
    .decode_valid   (decode_valid),
    .instr          (instr),
    .alu_opcode     (alu_opcode),
    .op1_sel        (op1_sel),
    .op2_sel        (op2_sel),
    .src2_sel       (src2_sel),
    .npc_sel        (npc_sel),
    .wdata_sel      (wdata_sel),
    .imm            (imm),
    .csr_write      (csr_write)
  );

  rv_execute execute0 (
    .clock            (clock),
    .reset            (reset),
    .block            (block),
    .clear_pipeline   (clear_pipeline),
    .decode_valid     (decode_valid),
    .idu_pc           (idu_pc),
    .src1             (src1),
    .src2             (src2),
    .csr_src          (csr_src),
    .imm              (imm),
    .alu_opcode       (alu_opcode),
    .op1_sel          (op1_sel),
    .op2_sel          (op2_sel),
    .src2_sel         (src2_sel),
    .npc_sel          (npc_sel),
    .wdata_sel        (wdata_sel),
    .csr_write        (csr_write),
    .exu_pc           (exu_pc),
    .execute_valid    (execute_valid),
    .alu_result       (alu_result),
    .exu_npc          (exu_npc),
    .exu_r_wdata      (exu_r_wdata),
    .csr_wdata        (csr_wdata),
    .wsrc             (wsrc),
    .wrong_prediction (wrong_prediction)
  );

endmodule

// File: tests/tb_clock.sv
module tb_clock (
  output logic clock,
  output logic reset
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // Ten rising edges in reset, released on a falling edge.
  initial begin
    reset = 1'b1;
    repeat (10) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
  end

endmodule

// File: tests/tb_execute.sv
`include "rv_defines.svh"

module tb_execute
  import rv_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int stim_cycles  = 400;
  localparam int clock_period = 8;

  logic              clock;
  logic              reset;
  logic              block;
  logic              clear_pipeline;
  logic              decode_valid;
  logic [31:0]       instr;
  logic [`XLEN-1:0]  idu_pc;
  logic [`XLEN-1:0]  src1;
  logic [`XLEN-1:0]  src2;
  logic [`XLEN-1:0]  csr_src;
  logic [`XLEN-1:0]  exu_pc;
  logic              execute_valid;
  logic [`XLEN-1:0]  alu_result;
  logic [`XLEN-1:0]  exu_npc;
  logic [`XLEN-1:0]  exu_r_wdata;
  logic [`XLEN-1:0]  csr_wdata;
  logic [`XLEN-1:0]  wsrc;
  logic              wrong_prediction;

  // Expectations for the instruction now on the inputs.
  logic              pend_valid;
  logic              pend_writes;
  logic              pend_csr_write;
  logic [4:0]        pend_rd;
  logic [`XLEN-1:0]  pend_pc;
  logic [`XLEN-1:0]  pend_result;
  logic [`XLEN-1:0]  pend_npc;
  logic [`XLEN-1:0]  pend_wdata;
  logic [`XLEN-1:0]  pend_wsrc;

  // Expectations for the instruction held in execute.
  logic              exp_valid;
  logic              exp_wrong;
  logic              exp_csr_write;
  logic [`XLEN-1:0]  exp_pc;
  logic [`XLEN-1:0]  exp_result;
  logic [`XLEN-1:0]  exp_npc;
  logic [`XLEN-1:0]  exp_wdata;
  logic [`XLEN-1:0]  exp_wsrc;
  logic              last_wen;
  logic [4:0]        last_rd;

  logic [31:0]       seed = 32'h096f3276;

  tb_clock clock0 (
    .clock (clock),
    .reset (reset)
  );

  rv_execute_top dut0 (
    .clock            (clock),
    .reset            (reset),
    .block            (block),
    .clear_pipeline   (clear_pipeline),
    .decode_valid     (decode_valid),
    .instr            (instr),
    .idu_pc           (idu_pc),
    .src1             (src1),
    .src2             (src2),
    .csr_src          (csr_src),
    .exu_pc           (exu_pc),
    .execute_valid    (execute_valid),
    .alu_result       (alu_result),
    .exu_npc          (exu_npc),
    .exu_r_wdata      (exu_r_wdata),
    .csr_wdata        (csr_wdata),
    .wsrc             (wsrc),
    .wrong_prediction (wrong_prediction)
  );

  function automatic logic [31:0] lcg();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed ^ (seed >> 15);
  endfunction

  // RV32I register and immediate arithmetic.
  function automatic logic [31:0] arith(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'd0, $signed(a) < $signed(b)};
      3'd3:    return {31'd0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic taken(input logic [2:0] f3, input logic [31:0] a,
                                 input logic [31:0] b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  // Registers limited to x0..x7 so dependencies come up often.
  function automatic logic [31:0] make_instr(input int kind);
    logic [31:0] w;
    w = lcg() & ~32'h018c_0c00;
    case (kind)
      0: begin
        w[6:0]   = 7'b0110011;
        w[31:25] = {1'b0, w[30], 5'd0};
      end
      1: begin
        w[6:0] = 7'b0010011;
        if (w[13:12] == 2'b01)
          w[31:25] = {1'b0, w[30], 5'd0};
      end
      2: w[6:0] = 7'b0110111;
      3: w[6:0] = 7'b0010111;
      4: w[6:0] = 7'b1101111;
      5: w[6:0] = 7'b1100111;
      6: begin
        w[6:0] = 7'b1100011;
        if (w[14:13] == 2'b01)
          w[14] = 1'b1;
      end
      7: w[6:0] = 7'b0100011;
      default: begin
        w[6:0]   = 7'b1110011;
        w[14:12] = w[12] ? 3'b001 : 3'b010;
      end
    endcase
    return w;
  endfunction

  task automatic predict(input logic [31:0] w, input logic [31:0] pc, input logic [31:0] s1,
                         input logic [31:0] s2, input logic [31:0] csr, input logic vld);
    logic [31:0] imm_i;
    logic [31:0] a;
    logic [31:0] b;
    logic [6:0]  opc;
    logic [2:0]  f3;
    opc   = w[6:0];
    f3    = w[14:12];
    imm_i = {{20{w[31]}}, w[31:20]};
    a = (last_wen && last_rd != 5'd0 && w[19:15] == last_rd) ? exp_wdata : s1;
    b = (last_wen && last_rd != 5'd0 && w[24:20] == last_rd) ? exp_wdata : s2;
    pend_valid     = vld;
    pend_pc        = pc;
    pend_rd        = w[11:7];
    pend_npc       = pc + `PC_STEP;
    pend_wsrc      = s2;
    pend_writes    = 1'b1;
    pend_csr_write = 1'b0;
    case (opc)
      7'b0110011: begin
        pend_result = arith(f3, w[30], a, b);
        pend_wsrc   = b;
      end
      7'b0010011: pend_result = arith(f3, w[30] && f3 == 3'd5, a, imm_i);
      7'b0110111: pend_result = {w[31:12], 12'd0};
      7'b0010111: pend_result = pc + {w[31:12], 12'd0};
      7'b1101111: begin
        pend_result = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        pend_npc    = pend_result;
      end
      7'b1100111: begin
        pend_result = a + imm_i;
        pend_npc    = pend_result & ~32'd1;
      end
      7'b1100011: begin
        pend_writes = 1'b0;
        pend_wsrc   = b;
        pend_result = {31'd0, taken(f3, a, b)};
        if (pend_result[0])
          pend_npc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      end
      7'b0100011: begin
        pend_writes = 1'b0;
        pend_wsrc   = b;
        pend_result = a + {{20{w[31]}}, w[31:25], w[11:7]};
      end
      default: begin
        pend_csr_write = 1'b1;
        pend_result    = (f3 == 3'b001) ? a : a | csr;
      end
    endcase
    case (opc)
      7'b1101111, 7'b1100111: pend_wdata = pc + `PC_STEP;
      7'b1110011:             pend_wdata = csr;
      default:                pend_wdata = pend_result;
    endcase
  endtask

  task automatic step(input int kind, input logic blk, input logic clr, input logic vld);
    logic [31:0] w;
    @(negedge clock);
    w              = make_instr(kind);
    instr          = w;
    idu_pc         = lcg() & ~32'd3;
    src1           = lcg();
    src2           = lcg();
    csr_src        = lcg();
    if (lcg() % 8 == 0)
      src2 = src1;
    block          = blk;
    clear_pipeline = clr;
    decode_valid   = vld;
    predict(w, idu_pc, src1, src2, csr_src, vld);
  endtask

  task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] want);
    $display("[ERROR] %0t ns: %s is %h, expected %h", $time, name, got, want);
    $display(">>> FAIL");
    $fatal(1, "%s mismatch", name);
  endtask

  // Reference pipeline register, one cycle ahead of the checks.
  always @(posedge clock) begin
    if (reset) begin
      exp_valid <= 1'b0;
      exp_wrong <= 1'b0;
      last_wen  <= 1'b0;
    end else if (!block) begin
      exp_wrong     <= !clear_pipeline && exp_valid && exp_npc != exp_pc + `PC_STEP;
      exp_valid     <= pend_valid && !clear_pipeline;
      exp_csr_write <= pend_valid && !clear_pipeline && pend_csr_write;
      last_wen      <= pend_valid && !clear_pipeline && pend_writes;
      last_rd       <= pend_rd;
      exp_pc        <= pend_pc;
      exp_result    <= pend_result;
      exp_npc       <= pend_npc;
      exp_wdata     <= pend_wdata;
      exp_wsrc      <= pend_wsrc;
    end
  end

  assert property (@(negedge clock) disable iff (reset) execute_valid == exp_valid)
    else mismatch("execute_valid", execute_valid, exp_valid);
  assert property (@(negedge clock) disable iff (reset) wrong_prediction == exp_wrong)
    else mismatch("wrong_prediction", wrong_prediction, exp_wrong);
  assert property (@(negedge clock) disable iff (reset) exp_valid |-> exu_pc == exp_pc)
    else mismatch("exu_pc", exu_pc, exp_pc);
  assert property (@(negedge clock) disable iff (reset) exp_valid |-> alu_result == exp_result)
    else mismatch("alu_result", alu_result, exp_result);
  assert property (@(negedge clock) disable iff (reset) exp_valid |-> exu_npc == exp_npc)
    else mismatch("exu_npc", exu_npc, exp_npc);
  assert property (@(negedge clock) disable iff (reset) exp_valid |-> exu_r_wdata == exp_wdata)
    else mismatch("exu_r_wdata", exu_r_wdata, exp_wdata);
  assert property (@(negedge clock) disable iff (reset) exp_valid |-> wsrc == exp_wsrc)
    else mismatch("wsrc", wsrc, exp_wsrc);
  assert property (@(negedge clock) disable iff (reset)
    exp_csr_write |-> csr_wdata == exp_result)
    else mismatch("csr_wdata", csr_wdata, exp_result);

  // A stalled edge leaves every output as it was.
  assert property (@(negedge clock) disable iff (reset)
    block |-> $stable({exu_pc, execute_valid, alu_result, exu_npc,
                       exu_r_wdata, csr_wdata, wsrc, wrong_prediction}))
    else begin
      $display("[ERROR] %0t ns: outputs changed while block was high", $time);
      $display(">>> FAIL");
      $fatal(1, "stall violated");
    end

  initial begin
    #(10 * stim_cycles * clock_period);
    $display("Timeout: the tests did not finish in time");
    $display(">>> FAIL");
    $fatal(1, "timeout");
  end

  initial begin
    instr          = 32'h0000_0013;
    idu_pc         = '0;
    src1           = '0;
    src2           = '0;
    csr_src        = '0;
    block          = 1'b0;
    clear_pipeline = 1'b0;
    decode_valid   = 1'b0;
    pend_valid     = 1'b0;
    wait (reset === 1'b0);
    repeat (120) step(lcg() % 2, 1'b0, 1'b0, 1'b1);
    // Control flow with some arithmetic mixed in.
    repeat (120) step(2 + lcg() % 5, 1'b0, 1'b0, 1'b1);
    step(8, 1'b0, 1'b0, 1'b1);
    repeat (60) step(lcg() % 9, 1'b0, 1'b0, 1'b1);
    repeat (80) step(lcg() % 9, lcg() % 4 == 0, lcg() % 8 == 0, lcg() % 8 != 0);
    step(0, 1'b0, 1'b0, 1'b0);
    repeat (2) @(negedge clock);
    $display(">>> PASS");
    $finish;
  end

endmodule

// File: files.f
+incdir+hw
hw/rv_pkg.sv
hw/rv_alu.sv
hw/rv_decoder.sv
hw/rv_execute.sv
hw/rv_execute_top.sv
tests/tb_clock.sv
tests/tb_execute.sv
